// ==== src/adc16_pkg.sv ====
package adc16_pkg;

  localparam int opb_dwidth = 32;  // opb data bus width.
  localparam int opb_awidth = 32;  // opb address bus width.

  localparam logic [1:0] controller_rev = 2'd1;  // version field in word 0 reads.

  localparam int n_lanes = 8;  // iserdes lanes per adc chip.

  // register index, taken from address bits [3:2] of the offset.
  typedef enum logic [1:0] {
    reg_3wire    = 2'd0,  // three-wire port and board identity.
    reg_ctrl     = 2'd1,  // control word.
    reg_delay_lo = 2'd2,  // delay reset lines 32 to 63.
    reg_delay_hi = 2'd3   // delay reset lines 0 to 31.
  } reg_sel_e;

  typedef enum logic {
    st_idle = 1'b0,  // waiting for a selected access.
    st_ack  = 1'b1   // transfer acknowledge cycle.
  } opb_state_e;

  typedef enum logic [1:0] {
    demux_by1   = 2'b00,  // single channel.
    demux_by2   = 2'b01,  // dual channel.
    demux_by4   = 2'b10,  // quad channel.
    demux_undef = 2'b11
  } demux_mode_e;

  // word 0 fields, opb bit numbering with bit 0 as msb.
  localparam int sclk_bit = 22;
  localparam int sdata_bit = 23;
  localparam int cs_msb = 24;  // chip select h.
  localparam int cs_lsb = 31;  // chip select a.

  // word 1 fields.
  localparam int demux_we_bit = 5;  // write strobe for the mode bits, never stored.
  localparam int demux_msb = 6;
  localparam int demux_lsb = 7;
  localparam int reset_bit = 11;
  localparam int snap_bit = 15;
  localparam int chip_msb = 16;  // bitslip chip h.
  localparam int chip_lsb = 23;  // bitslip chip a.
  localparam int lane_msb = 24;
  localparam int lane_lsb = 26;
  localparam int tap_msb = 27;
  localparam int tap_lsb = 31;

endpackage

// ==== src/opb_adc16_regs.sv ====
`timescale 1ns/1ps

module opb_adc16_regs #(
  parameter logic [31:0] C_BASEADDR = 32'h0000_0000,
  parameter logic [31:0] C_HIGHADDR = 32'h0000_ffff,
  parameter logic [1:0]  ROACH2_REV = 2'd2,
  parameter logic [1:0]  ZDOK_REV   = 2'd1,
  parameter logic [3:0]  NUM_UNITS  = 4'd4
) (
  input  logic                               OPB_Clk,
  input  logic                               rst,
  input  logic [0:adc16_pkg::opb_awidth-1]   OPB_ABus,
  input  logic [0:3]                         OPB_BE,
  input  logic [0:adc16_pkg::opb_dwidth-1]   OPB_DBus,
  input  logic                               OPB_RNW,
  input  logic                               OPB_select,
  input  logic [1:0]                         adc16_locked,
  output logic [0:adc16_pkg::opb_dwidth-1]   Sl_DBus,
  output logic                               Sl_xferAck,
  output logic                               adc3wire_sclk,
  output logic                               adc3wire_sdata,
  output logic [0:7]                         adc3wire_cs,
  output logic                               adc16_reset,
  output logic                               adc16_snap_req,
  output adc16_pkg::demux_mode_e             adc16_demux_mode,
  output logic [0:4]                         adc16_delay_tap,
  output logic [0:63]                        adc16_delay_rst,
  output logic [0:7]                         bitslip_chip_sel,
  output logic [0:2]                         bitslip_lane_sel
);

  adc16_pkg::opb_state_e state;  // slave handshake state.
  adc16_pkg::reg_sel_e reg_sel;  // word addressed by the current access.

  logic [adc16_pkg::opb_awidth-1:0] addr_off;  // offset from the base address.
  logic addr_match;  // address inside the window.
  logic access;  // first cycle of a selected in-window access.

  logic [0:31] wire3_reg;  // word 0, bit-banged three-wire port.
  logic [0:31] ctrl_reg;  // word 1.
  logic [0:63] delay_reg;  // words 3 and 2, per-lane delay reset.

  logic [0:31] ctrl_wr;  // word 1 after merge and mode gating.
  logic [0:31] rd_mux;  // read value for the addressed word.
  logic [0:31] rd_data;  // captured on the ack edge.

  logic [1:0] locked_meta;  // first synchronizer stage.
  logic [1:0] locked_sync;  // second stage, safe to read.

  // replace the enabled byte lanes of cur with wdata.
  function automatic logic [0:31] be_merge(input logic [0:31] cur,
                                           input logic [0:31] wdata,
                                           input logic [0:3]  be);
    logic [0:31] res;
    res = cur;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = wdata[b*8 +: 8];  // byte lane 0 is the msb byte.
      end
    end
    return res;
  endfunction

  assign addr_off = OPB_ABus - C_BASEADDR;
  assign addr_match = (OPB_ABus >= C_BASEADDR) && (OPB_ABus <= C_HIGHADDR);
  assign reg_sel = adc16_pkg::reg_sel_e'(addr_off[3:2]);  // word index.
  assign access = OPB_select && addr_match && (state == adc16_pkg::st_idle);

  // one ack per access, and st_ack always falls back to idle so the
  // master's held select is not taken as a second request
  always_ff @(posedge OPB_Clk) begin
    if (rst) begin
      state <= adc16_pkg::st_idle;
    end else begin
      case (state)
        adc16_pkg::st_idle: begin
          if (access) begin
            state <= adc16_pkg::st_ack;  // ack on the next cycle.
          end
        end
        adc16_pkg::st_ack: begin
          state <= adc16_pkg::st_idle;
        end
        default: begin
          state <= adc16_pkg::st_idle;
        end
      endcase
    end
  end

  // word 1 write value
  always_comb begin
    ctrl_wr = be_merge(ctrl_reg, OPB_DBus, OPB_BE);
    ctrl_wr[adc16_pkg::demux_we_bit] = 1'b0;  // strobe bit reads as zero.
    if (!(OPB_BE[0] && OPB_DBus[adc16_pkg::demux_we_bit])) begin
      ctrl_wr[adc16_pkg::demux_msb:adc16_pkg::demux_lsb] =
        ctrl_reg[adc16_pkg::demux_msb:adc16_pkg::demux_lsb];  // mode held.
    end
  end

  // register file is written on the edge that raises the ack
  always_ff @(posedge OPB_Clk) begin
    if (rst) begin
      wire3_reg <= '0;
      ctrl_reg <= '0;
      delay_reg <= '0;
    end else if (access && !OPB_RNW) begin
      case (reg_sel)
        adc16_pkg::reg_3wire: begin
          wire3_reg <= be_merge(wire3_reg, OPB_DBus, OPB_BE);
        end
        adc16_pkg::reg_ctrl: begin
          ctrl_reg <= ctrl_wr;
        end
        adc16_pkg::reg_delay_lo: begin
          delay_reg[32:63] <= be_merge(delay_reg[32:63], OPB_DBus, OPB_BE);  // lsb half.
        end
        adc16_pkg::reg_delay_hi: begin
          delay_reg[0:31] <= be_merge(delay_reg[0:31], OPB_DBus, OPB_BE);  // msb half.
        end
        default: begin
          ctrl_reg <= ctrl_reg;
        end
      endcase
    end
  end

  // lock status comes from the adc clock domains.
  always_ff @(posedge OPB_Clk) begin
    if (rst) begin
      locked_meta <= '0;
      locked_sync <= '0;
    end else begin
      locked_meta <= adc16_locked;
      locked_sync <= locked_meta;
    end
  end

  always_comb begin
    rd_mux = '0;
    case (reg_sel)
      adc16_pkg::reg_3wire: begin
        rd_mux = {2'b00, ZDOK_REV, 2'b00, locked_sync, NUM_UNITS,
                  adc16_pkg::controller_rev, ROACH2_REV,
                  wire3_reg[16:31]};  // identity over the live port bits.
      end
      adc16_pkg::reg_ctrl: begin
        rd_mux = ctrl_reg;
      end
      adc16_pkg::reg_delay_lo: begin
        rd_mux = delay_reg[32:63];
      end
      adc16_pkg::reg_delay_hi: begin
        rd_mux = delay_reg[0:31];
      end
      default: begin
        rd_mux = '0;
      end
    endcase
  end

  always_ff @(posedge OPB_Clk) begin
    if (access && OPB_RNW) begin
      rd_data <= rd_mux;  // only driven out while acked.
    end
  end

  assign Sl_xferAck = (state == adc16_pkg::st_ack);
  assign Sl_DBus = Sl_xferAck ? rd_data : '0;  // bus is or-ed with other slaves.

  assign adc3wire_sclk = wire3_reg[adc16_pkg::sclk_bit];
  assign adc3wire_sdata = wire3_reg[adc16_pkg::sdata_bit];
  assign adc3wire_cs = wire3_reg[adc16_pkg::cs_msb:adc16_pkg::cs_lsb];  // active high here.

  assign adc16_demux_mode =
    adc16_pkg::demux_mode_e'(ctrl_reg[adc16_pkg::demux_msb:adc16_pkg::demux_lsb]);
  assign adc16_reset = ctrl_reg[adc16_pkg::reset_bit];
  assign adc16_snap_req = ctrl_reg[adc16_pkg::snap_bit];
  assign bitslip_chip_sel = ctrl_reg[adc16_pkg::chip_msb:adc16_pkg::chip_lsb];
  assign bitslip_lane_sel = ctrl_reg[adc16_pkg::lane_msb:adc16_pkg::lane_lsb];
  assign adc16_delay_tap = ctrl_reg[adc16_pkg::tap_msb:adc16_pkg::tap_lsb];
  assign adc16_delay_rst = delay_reg;

  // an acked cycle is always followed by a cycle without ack.
  ack_single_cycle: assert property (
    @(posedge OPB_Clk) disable iff (rst)
    Sl_xferAck |=> !Sl_xferAck
  ) else $error("opb ack held for more than one cycle");

  // idle bus must not disturb reads from other slaves.
  dbus_quiet: assert property (
    @(posedge OPB_Clk) disable iff (rst)
    (state == adc16_pkg::st_idle) |-> (Sl_DBus == '0)
  ) else $error("Sl_DBus driven without ack");

endmodule

// ==== src/opb_adc16_onehot_encoder.sv ====
`timescale 1ns/1ps

module opb_adc16_onehot_encoder #(
  parameter int N_CHIPS = 8
) (
  input  logic                                   OPB_Clk,
  input  logic                                   rst,
  input  logic [0:N_CHIPS-1]                     chip_sel,  // chip a at the last bit.
  input  logic [0:2]                             lane_sel,
  output logic [0:N_CHIPS*adc16_pkg::n_lanes-1]  bitslip
);

  logic [0:N_CHIPS-1] chip_prev;  // chip_sel from the previous cycle.
  logic [0:N_CHIPS-1] chip_rise;  // chips newly selected this cycle.
  logic [0:N_CHIPS*adc16_pkg::n_lanes-1] slip_d;  // next pulse pattern.

  assign chip_rise = chip_sel & ~chip_prev;

  // chip_sel bit i is chip number N_CHIPS-1-i. counted from the lsb end its
  // lanes sit at chip*n_lanes+lane, which in msb-first numbering is the
  // group i*n_lanes with lane 0 at the right of the group
  always_comb begin
    slip_d = '0;
    for (int i = 0; i < N_CHIPS; i++) begin
      for (int l = 0; l < adc16_pkg::n_lanes; l++) begin
        if (chip_rise[i] && (lane_sel == 3'(l))) begin
          slip_d[i*adc16_pkg::n_lanes + adc16_pkg::n_lanes-1 - l] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge OPB_Clk) begin
    if (rst) begin
      chip_prev <= '0;
      bitslip <= '0;
    end else begin
      chip_prev <= chip_sel;  // a held chip bit gives no second pulse.
      bitslip <= slip_d;  // one registered cycle per rise.
    end
  end

  for (genvar g = 0; g < N_CHIPS; g++) begin : g_chip_check
    // only one lane of a chip can slip at a time.
    one_lane_per_chip: assert property (
      @(posedge OPB_Clk) disable iff (rst)
      $onehot0(bitslip[g*adc16_pkg::n_lanes +: adc16_pkg::n_lanes])
    ) else $error("several bitslip lanes of one chip active");
  end

endmodule

// ==== src/adc16_ctrl_top.sv ====
`timescale 1ns/1ps

module adc16_ctrl_top #(
  parameter logic [31:0] C_BASEADDR = 32'h0000_0000,
  parameter logic [31:0] C_HIGHADDR = 32'h0000_ffff,
  parameter logic [1:0]  ROACH2_REV = 2'd2,
  parameter logic [1:0]  ZDOK_REV   = 2'd1,
  parameter logic [3:0]  NUM_UNITS  = 4'd4,
  parameter int          N_CHIPS    = 8  // at most 8 with chip a always present.
) (
  input  logic                                   OPB_Clk,
  input  logic                                   rst,
  input  logic [0:adc16_pkg::opb_awidth-1]       OPB_ABus,
  input  logic [0:3]                             OPB_BE,
  input  logic [0:adc16_pkg::opb_dwidth-1]       OPB_DBus,
  input  logic                                   OPB_RNW,
  input  logic                                   OPB_select,
  input  logic                                   OPB_seqAddr,
  input  logic [1:0]                             adc16_locked,
  output logic [0:adc16_pkg::opb_dwidth-1]       Sl_DBus,
  output logic                                   Sl_errAck,
  output logic                                   Sl_retry,
  output logic                                   Sl_toutSup,
  output logic                                   Sl_xferAck,
  output logic                                   adc0_adc3wire_csn1,
  output logic                                   adc0_adc3wire_csn2,
  output logic                                   adc0_adc3wire_csn3,
  output logic                                   adc0_adc3wire_csn4,
  output logic                                   adc0_adc3wire_sdata,
  output logic                                   adc0_adc3wire_sclk,
  output logic                                   adc1_adc3wire_csn1,
  output logic                                   adc1_adc3wire_csn2,
  output logic                                   adc1_adc3wire_csn3,
  output logic                                   adc1_adc3wire_csn4,
  output logic                                   adc1_adc3wire_sdata,
  output logic                                   adc1_adc3wire_sclk,
  output logic                                   adc16_reset,
  output logic [0:N_CHIPS*adc16_pkg::n_lanes-1]  adc16_iserdes_bitslip,
  output logic [0:63]                            adc16_delay_rst,
  output logic [0:4]                             adc16_delay_tap,
  output logic                                   adc16_snap_req,
  output logic [0:1]                             adc16_demux_mode
);

  localparam int cs_w = adc16_pkg::cs_lsb - adc16_pkg::cs_msb + 1;  // 8 chip selects.

  logic [0:cs_w-1] cs;  // active high selects from word 0.
  logic sclk;
  logic sdata;
  logic [0:7] chip_sel;  // bitslip chip h to a.
  logic [0:2] lane_sel;
  adc16_pkg::demux_mode_e demux_mode;

  opb_adc16_regs #(
    .C_BASEADDR (C_BASEADDR),
    .C_HIGHADDR (C_HIGHADDR),
    .ROACH2_REV (ROACH2_REV),
    .ZDOK_REV   (ZDOK_REV),
    .NUM_UNITS  (NUM_UNITS)
  ) u_regs (
    .OPB_Clk          (OPB_Clk),
    .rst              (rst),
    .OPB_ABus         (OPB_ABus),
    .OPB_BE           (OPB_BE),
    .OPB_DBus         (OPB_DBus),
    .OPB_RNW          (OPB_RNW),
    .OPB_select       (OPB_select),
    .adc16_locked     (adc16_locked),
    .Sl_DBus          (Sl_DBus),
    .Sl_xferAck       (Sl_xferAck),
    .adc3wire_sclk    (sclk),
    .adc3wire_sdata   (sdata),
    .adc3wire_cs      (cs),
    .adc16_reset      (adc16_reset),
    .adc16_snap_req   (adc16_snap_req),
    .adc16_demux_mode (demux_mode),
    .adc16_delay_tap  (adc16_delay_tap),
    .adc16_delay_rst  (adc16_delay_rst),
    .bitslip_chip_sel (chip_sel),
    .bitslip_lane_sel (lane_sel)
  );

  opb_adc16_onehot_encoder #(
    .N_CHIPS (N_CHIPS)
  ) u_encoder (
    .OPB_Clk  (OPB_Clk),
    .rst      (rst),
    .chip_sel (chip_sel[8-N_CHIPS:7]),  // keeps chip a at the last bit.
    .lane_sel (lane_sel),
    .bitslip  (adc16_iserdes_bitslip)
  );

  assign adc16_demux_mode = demux_mode;

  assign Sl_errAck = 1'b0;  // no error, retry or timeout support.
  assign Sl_retry = 1'b0;
  assign Sl_toutSup = 1'b0;

  // both boards share clock and data of the three-wire port.
  assign adc0_adc3wire_sclk = sclk;
  assign adc1_adc3wire_sclk = sclk;
  assign adc0_adc3wire_sdata = sdata;
  assign adc1_adc3wire_sdata = sdata;

  // upper four selects go to adc1 and lower four to adc0 with active low pins.
  assign adc1_adc3wire_csn4 = ~cs[0];
  assign adc1_adc3wire_csn3 = ~cs[1];
  assign adc1_adc3wire_csn2 = ~cs[2];
  assign adc1_adc3wire_csn1 = ~cs[3];
  assign adc0_adc3wire_csn4 = ~cs[4];
  assign adc0_adc3wire_csn3 = ~cs[5];
  assign adc0_adc3wire_csn2 = ~cs[6];
  assign adc0_adc3wire_csn1 = ~cs[7];

endmodule

// ==== test/tb_adc16_ctrl_table.svh ====
localparam int n_rows = 32;

row_t rows [n_rows];

task automatic fill_rows();
  // op, word, byte enable (bit 3 is byte lane 0), random data, data,
  // expected read value, expected pins {csn, sclk/sdata x2, reset, snap, demux, tap}
  rows[0] = '{op_rd, adc16_pkg::reg_3wire, 4'hf, 1'b0, 32'h0, {id_hi, 16'h0000}, 32'hff00_0000};
  rows[1] = '{op_rd, adc16_pkg::reg_ctrl, 4'hf, 1'b0, 32'h0, 32'h0, 32'hff00_0000};
  rows[2] = '{op_rd, adc16_pkg::reg_delay_lo, 4'hf, 1'b0, 32'h0, 32'h0, 32'hff00_0000};
  rows[3] = '{op_rd, adc16_pkg::reg_delay_hi, 4'hf, 1'b0, 32'h0, 32'h0, 32'hff00_0000};
  rows[4] = '{op_wr, adc16_pkg::reg_3wire, 4'hf, 1'b0, 32'h0000_0283, 32'h0, 32'h7ca0_0000};
  rows[5] = '{op_rd, adc16_pkg::reg_3wire, 4'hf, 1'b0, 32'h0, {id_hi, 16'h0283}, 32'h7ca0_0000};
  rows[6] = '{op_wr, adc16_pkg::reg_3wire, 4'h1, 1'b0, 32'hffff_ff50, 32'h0, 32'hafa0_0000};
  rows[7] = '{op_rd, adc16_pkg::reg_3wire, 4'hf, 1'b0, 32'h0, {id_hi, 16'h0250}, 32'hafa0_0000};
  rows[8] = '{op_wr, adc16_pkg::reg_3wire, 4'h2, 1'b0, 32'h0000_0100, 32'h0, 32'haf50_0000};
  rows[9] = '{op_wr, adc16_pkg::reg_ctrl, 4'hf, 1'b0, 32'h0211_0015, 32'h0, 32'haf5c_0015};
  rows[10] = '{op_rd, adc16_pkg::reg_ctrl, 4'hf, 1'b0, 32'h0, 32'h0011_0015, 32'haf5c_0015};
  rows[11] = '{op_wr, adc16_pkg::reg_ctrl, 4'hf, 1'b0, 32'h0600_0000, 32'h0, 32'haf52_0000};
  rows[12] = '{op_rd, adc16_pkg::reg_ctrl, 4'hf, 1'b0, 32'h0, 32'h0200_0000, 32'haf52_0000};
  rows[13] = '{op_wr, adc16_pkg::reg_ctrl, 4'hf, 1'b0, 32'h0100_0000, 32'h0, 32'haf52_0000};
  rows[14] = '{op_wr, adc16_pkg::reg_ctrl, 4'h3, 1'b0, 32'h0000_0460, 32'h0, 32'haf52_0000};
  rows[15] = '{op_wr, adc16_pkg::reg_ctrl, 4'h3, 1'b0, 32'h0000_04a0, 32'h0, 32'haf52_0000};
  rows[16] = '{op_wr, adc16_pkg::reg_ctrl, 4'h3, 1'b0, 32'h0000_01e0, 32'h0, 32'haf52_0000};
  rows[17] = '{op_wr, adc16_pkg::reg_ctrl, 4'h3, 1'b0, 32'h0000_8400, 32'h0, 32'haf52_0000};
  rows[18] = '{op_wr, adc16_pkg::reg_delay_lo, 4'hf, 1'b0, 32'h8000_0001, 32'h0, 32'haf52_0000};
  rows[19] = '{op_wr, adc16_pkg::reg_delay_hi, 4'hf, 1'b0, 32'h0123_4567, 32'h0, 32'haf52_0000};
  rows[20] = '{op_rd, adc16_pkg::reg_delay_lo, 4'hf, 1'b0, 32'h0, 32'h8000_0001, 32'haf52_0000};
  rows[21] = '{op_rd, adc16_pkg::reg_delay_hi, 4'hf, 1'b0, 32'h0, 32'h0123_4567, 32'haf52_0000};
  rows[22] = '{op_wr, adc16_pkg::reg_ctrl, 4'h5, 1'b1, 32'h0, 32'h0, 32'h0};
  rows[23] = '{op_rd, adc16_pkg::reg_ctrl, 4'hf, 1'b1, 32'h0, 32'h0, 32'h0};
  rows[24] = '{op_wr, adc16_pkg::reg_delay_lo, 4'ha, 1'b1, 32'h0, 32'h0, 32'h0};
  rows[25] = '{op_rd, adc16_pkg::reg_delay_lo, 4'hf, 1'b1, 32'h0, 32'h0, 32'h0};
  rows[26] = '{op_wr, adc16_pkg::reg_delay_hi, 4'h9, 1'b1, 32'h0, 32'h0, 32'h0};
  rows[27] = '{op_rd, adc16_pkg::reg_delay_hi, 4'hf, 1'b1, 32'h0, 32'h0, 32'h0};
  rows[28] = '{op_wr, adc16_pkg::reg_ctrl, 4'hc, 1'b1, 32'h0, 32'h0, 32'h0};
  rows[29] = '{op_rd, adc16_pkg::reg_ctrl, 4'hf, 1'b1, 32'h0, 32'h0, 32'h0};
  rows[30] = '{op_probe, adc16_pkg::reg_ctrl, 4'hf, 1'b1, 32'h0, 32'h0, 32'h0};
  rows[31] = '{op_rd, adc16_pkg::reg_3wire, 4'hf, 1'b1, 32'h0, 32'h0, 32'h0};
endtask

// ==== test/tb_adc16_ctrl.sv ====
`timescale 1ns/1ps

module tb_adc16_ctrl;

  localparam logic [31:0] c_baseaddr = 32'h0001_0000;
  localparam logic [31:0] c_highaddr = 32'h0001_00ff;
  localparam logic [1:0]  roach2_rev = 2'd2;
  localparam logic [1:0]  zdok_rev   = 2'd1;
  localparam logic [3:0]  num_units  = 4'd4;
  localparam logic [1:0]  lock_val   = 2'b10;  // held for the whole run.
  localparam logic [15:0] id_hi = {2'b00, zdok_rev, 2'b00, lock_val, num_units,
                                   adc16_pkg::controller_rev, roach2_rev};  // word 0 upper half.

  typedef enum logic [1:0] {op_wr, op_rd, op_probe} op_e;

  typedef struct packed {
    op_e op;
    adc16_pkg::reg_sel_e sel;
    logic [3:0] be;
    logic rnd;  // data from $urandom, expectations from the shadow model.
    logic [31:0] data;
    logic [31:0] exp_rd;
    logic [31:0] exp_pins;
  } row_t;

  logic OPB_Clk;
  logic rst;
  logic [31:0] OPB_ABus;
  logic [3:0] OPB_BE;
  logic [31:0] OPB_DBus;
  logic OPB_RNW;
  logic OPB_select;
  logic OPB_seqAddr;
  logic [1:0] adc16_locked;
  logic [31:0] Sl_DBus;
  logic Sl_errAck, Sl_retry, Sl_toutSup, Sl_xferAck;
  logic adc0_csn1, adc0_csn2, adc0_csn3, adc0_csn4, adc0_sdata, adc0_sclk;
  logic adc1_csn1, adc1_csn2, adc1_csn3, adc1_csn4, adc1_sdata, adc1_sclk;
  logic adc16_reset, adc16_snap_req;
  logic [63:0] adc16_iserdes_bitslip;
  logic [63:0] adc16_delay_rst;
  logic [4:0] adc16_delay_tap;
  logic [1:0] adc16_demux_mode;

  int n_errors = 0;
  int n_checks = 0;
  logic [31:0] sh [4];  // shadow of the four words.
  logic [63:0] slip_at_ack;  // bitslip lines seen during the ack cycle.
  logic [31:0] pins;  // board pins and control outputs in one word.

  `include "tb_adc16_ctrl_table.svh"

  adc16_ctrl_top #(
    .C_BASEADDR (c_baseaddr),
    .C_HIGHADDR (c_highaddr),
    .ROACH2_REV (roach2_rev),
    .ZDOK_REV   (zdok_rev),
    .NUM_UNITS  (num_units),
    .N_CHIPS    (8)
  ) u_adc16_ctrl_top (
    .OPB_Clk (OPB_Clk), .rst (rst), .OPB_ABus (OPB_ABus), .OPB_BE (OPB_BE),
    .OPB_DBus (OPB_DBus), .OPB_RNW (OPB_RNW), .OPB_select (OPB_select),
    .OPB_seqAddr (OPB_seqAddr), .adc16_locked (adc16_locked), .Sl_DBus (Sl_DBus),
    .Sl_errAck (Sl_errAck), .Sl_retry (Sl_retry), .Sl_toutSup (Sl_toutSup),
    .Sl_xferAck (Sl_xferAck),
    .adc0_adc3wire_csn1 (adc0_csn1), .adc0_adc3wire_csn2 (adc0_csn2),
    .adc0_adc3wire_csn3 (adc0_csn3), .adc0_adc3wire_csn4 (adc0_csn4),
    .adc0_adc3wire_sdata (adc0_sdata), .adc0_adc3wire_sclk (adc0_sclk),
    .adc1_adc3wire_csn1 (adc1_csn1), .adc1_adc3wire_csn2 (adc1_csn2),
    .adc1_adc3wire_csn3 (adc1_csn3), .adc1_adc3wire_csn4 (adc1_csn4),
    .adc1_adc3wire_sdata (adc1_sdata), .adc1_adc3wire_sclk (adc1_sclk),
    .adc16_reset (adc16_reset), .adc16_iserdes_bitslip (adc16_iserdes_bitslip),
    .adc16_delay_rst (adc16_delay_rst), .adc16_delay_tap (adc16_delay_tap),
    .adc16_snap_req (adc16_snap_req), .adc16_demux_mode (adc16_demux_mode)
  );

  assign pins = {adc1_csn4, adc1_csn3, adc1_csn2, adc1_csn1,
                 adc0_csn4, adc0_csn3, adc0_csn2, adc0_csn1,
                 adc0_sclk, adc0_sdata, adc1_sclk, adc1_sdata,
                 adc16_reset, adc16_snap_req, adc16_demux_mode, 11'd0, adc16_delay_tap};

  initial begin
    OPB_Clk = 1'b0;
    forever #20 OPB_Clk = ~OPB_Clk;  // 25 mhz opb clock.
  end

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // byte merge followed by the demux strobe rule on word 1.
  task automatic shadow_write(input adc16_pkg::reg_sel_e sel, input logic [3:0] be,
                              input logic [31:0] d);
    logic [31:0] m;
    m = sh[sel];
    for (int k = 0; k < 4; k++) begin
      if (be[k]) m[k*8 +: 8] = d[k*8 +: 8];  // be bit 3 is the msb byte.
    end
    if (sel == adc16_pkg::reg_ctrl) begin
      m[31-adc16_pkg::demux_we_bit] = 1'b0;
      if (!(be[3] && d[31-adc16_pkg::demux_we_bit])) begin
        m[31-adc16_pkg::demux_lsb +: 2] = sh[1][31-adc16_pkg::demux_lsb +: 2];
      end
    end
    sh[sel] = m;
  endtask

  function automatic logic [31:0] expected_read(input adc16_pkg::reg_sel_e sel);
    if (sel == adc16_pkg::reg_3wire) return {id_hi, sh[0][15:0]};
    return sh[sel];
  endfunction

  function automatic logic [31:0] expected_pins();
    return {~sh[0][31-adc16_pkg::cs_lsb +: 8],
            sh[0][31-adc16_pkg::sclk_bit], sh[0][31-adc16_pkg::sdata_bit],
            sh[0][31-adc16_pkg::sclk_bit], sh[0][31-adc16_pkg::sdata_bit],
            sh[1][31-adc16_pkg::reset_bit], sh[1][31-adc16_pkg::snap_bit],
            sh[1][31-adc16_pkg::demux_lsb +: 2], 11'd0, sh[1][31-adc16_pkg::tap_lsb +: 5]};
  endfunction

  // chip c sits at word 1 bit 8+c, its lane l at line c*n_lanes+l from the lsb.
  function automatic logic [63:0] slip_pattern(input logic [7:0] old_chips,
                                               input logic [31:0] new_ctrl);
    logic [7:0] rise;
    logic [2:0] lane;
    logic [63:0] pat;
    rise = new_ctrl[31-adc16_pkg::chip_lsb +: 8] & ~old_chips;
    lane = new_ctrl[31-adc16_pkg::lane_lsb +: 3];
    pat = '0;
    for (int c = 0; c < 8; c++) begin
      if (rise[c]) pat[c*adc16_pkg::n_lanes + int'(lane)] = 1'b1;
    end
    return pat;
  endfunction

  task automatic opb_access(input logic rnw, input logic [31:0] addr, input logic [3:0] be,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic acked);
    int n;
    @(posedge OPB_Clk);
    OPB_ABus <= addr;
    OPB_BE <= be;
    OPB_DBus <= rnw ? 32'h0 : wdata;
    OPB_RNW <= rnw;
    OPB_select <= 1'b1;
    acked = 1'b0;
    rdata = '0;
    n = 0;
    while (!acked && n < 16) begin  // ack timeout.
      @(negedge OPB_Clk);
      n++;
      if (Sl_xferAck) begin
        acked = 1'b1;
        rdata = Sl_DBus;
        slip_at_ack = adc16_iserdes_bitslip;
      end
    end
    if (acked) begin
      check("Sl_xferAck latency", 64'(n), 64'd2);  // one cycle after select is seen.
    end
    @(posedge OPB_Clk);
    OPB_select <= 1'b0;  // master releases after the ack.
    OPB_RNW <= 1'b1;
    OPB_BE <= 4'h0;
    OPB_DBus <= '0;
  endtask

  // tied-off responses and the quiet read bus.
  always @(negedge OPB_Clk) begin
    if (!rst) begin
      check("Sl_errAck", 64'(Sl_errAck), 64'd0);
      check("Sl_retry", 64'(Sl_retry), 64'd0);
      check("Sl_toutSup", 64'(Sl_toutSup), 64'd0);
      if (!Sl_xferAck) check("Sl_DBus", 64'(Sl_DBus), 64'd0);
    end
  end

  initial begin : main_seq
    row_t r;
    logic [31:0] addr, wdata, rdata;
    logic acked;
    logic [7:0] old_chips;
    logic [63:0] exp_slip;
    rst = 1'b1;
    OPB_ABus = '0;
    OPB_BE = 4'h0;
    OPB_DBus = '0;
    OPB_RNW = 1'b1;
    OPB_select = 1'b0;
    OPB_seqAddr = 1'b0;
    adc16_locked = lock_val;
    slip_at_ack = '0;
    for (int k = 0; k < 4; k++) sh[k] = '0;
    void'($urandom(32'hb89fc105));
    fill_rows();
    repeat (8) @(posedge OPB_Clk);
    rst <= 1'b0;
    @(negedge OPB_Clk);
    check("Sl_xferAck", 64'(Sl_xferAck), 64'd0);
    check("adc16_iserdes_bitslip", adc16_iserdes_bitslip, 64'd0);
    check("adc16_delay_rst", adc16_delay_rst, 64'd0);
    repeat (4) @(posedge OPB_Clk);  // lock bits pass the synchronizer.
    for (int i = 0; i < n_rows; i++) begin
      r = rows[i];
      addr = (r.op == op_probe) ? c_highaddr + 32'h4 : c_baseaddr + {28'd0, r.sel, 2'b00};
      wdata = r.rnd ? $urandom() : r.data;
      exp_slip = '0;
      slip_at_ack = '0;
      if (r.op == op_wr) begin
        old_chips = sh[1][31-adc16_pkg::chip_lsb +: 8];
        shadow_write(r.sel, r.be, wdata);
        if (r.sel == adc16_pkg::reg_ctrl) exp_slip = slip_pattern(old_chips, sh[1]);
      end
      opb_access(r.op != op_wr, addr, r.be, wdata, rdata, acked);
      if (r.op == op_probe) begin
        if (acked) begin
          n_errors++;
          $display("access to 0x%08h outside the window was acknowledged", addr);
        end
      end else if (!acked) begin
        n_errors++;
        $display("no ack within 16 cycles for row %0d at address 0x%08h", i, addr);
      end
      if (r.op == op_rd) begin
        check("Sl_DBus", 64'(rdata), 64'(r.rnd ? expected_read(r.sel) : r.exp_rd));
      end
      @(negedge OPB_Clk);
      check("Sl_xferAck", 64'(Sl_xferAck), 64'd0);  // ack lasts a single cycle.
      check("pins", 64'(pins), 64'(r.rnd ? expected_pins() : r.exp_pins));
      check("adc16_delay_rst", adc16_delay_rst, {sh[3], sh[2]});
      check("adc16_iserdes_bitslip at ack", slip_at_ack, 64'd0);
      check("adc16_iserdes_bitslip", adc16_iserdes_bitslip, exp_slip);  // the pulse cycle.
      @(negedge OPB_Clk);
      check("adc16_iserdes_bitslip after pulse", adc16_iserdes_bitslip, 64'd0);
    end
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+test
src/adc16_pkg.sv
src/opb_adc16_regs.sv
src/opb_adc16_onehot_encoder.sv
src/adc16_ctrl_top.sv
test/tb_adc16_ctrl.sv

// ==== Makefile ====
TOOL       = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = tb_adc16_ctrl
FILELIST   = filelist.f
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Finished with errors" $(LOG) || ! grep -q "Finished with no errors" $(LOG); \
	then echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)
